/* bench/aluCoreTb.sv */
module aluCoreTb import aluPkg::*; ();

    localparam int dataWidth = 16;
    localparam int maxU      = (1 << dataWidth) - 1;        // Largest unsigned value
    localparam int maxS      = (1 << (dataWidth - 1)) - 1;  // Signed range limits
    localparam int minS      = -(1 << (dataWidth - 1));
    // About 360 instructions at up to 3 cycles each with gaps plus drains
    localparam int maxCycles = 2000;

    logic                 clk;
    logic                 arstN;
    logic                 instrValid;
    instrWordU            instr;
    logic [dataWidth-1:0] result;
    logic                 resultValid;
    logic                 flagZ, flagC, flagS, flagO;

    logic [dataWidth-1:0] shadow [8];                       // Register file as the model sees it
    logic [dataWidth+3:0] expQ [$];                         // {Z, C, S, O, result} per instruction
    int                   cycQ [$];                         // Issue cycle per instruction
    string                nameQ [$];
    logic [dataWidth+3:0] gotExp;
    int                   gotCyc;
    string                gotName;
    string                curTest;
    logic [31:0]          seed;
    int                   cycleCount = 0;
    int                   errCount = 0;
    int                   checkCount = 0;
    int                   testCount = 0;
    int                   errAtStart = 0;

    aluCore #(.dataWidth(dataWidth)) aluCore_inst (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .result     (result),
        .resultValid(resultValid),
        .flagZ      (flagZ),
        .flagC      (flagC),
        .flagS      (flagS),
        .flagO      (flagO)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;       // Numerical Recipes LCG
        return seed;
    endfunction

    // Expected result and flags from the opcode table
    function automatic logic [dataWidth+3:0] refAlu(input logic [opWidth-1:0] op,
            input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        int                   ua, ub, sa, sb, uSum, sSum, extra;
        logic [dataWidth-1:0] y;
        logic                 c, o;
        ua = int'(a);
        ub = int'(b);
        sa = int'($signed(a));
        sb = int'($signed(b));
        y  = '0;
        c  = 1'b0;
        o  = 1'b0;
        if (op == opInc || op == opDec) begin               // One-operand forms ignore B
            ub = 0;
            sb = 0;
        end
        extra = (op == opAdd || op == opSub) ? 0 : 1;       // The implied +1 or -1
        case (op)
            opAdd, opAddInc, opInc: begin
                uSum = ua + ub + extra;
                sSum = sa + sb + extra;
                y    = uSum[dataWidth-1:0];
                c    = uSum > maxU;
                o    = (sSum > maxS) || (sSum < minS);
            end
            opSubDec, opSub, opDec: begin
                uSum = ua - ub - extra;
                sSum = sa - sb - extra;
                y    = uSum[dataWidth-1:0];
                c    = (ub + extra) > ua;                   // Borrow
                o    = (sSum > maxS) || (sSum < minS);
            end
            opShl: begin
                y = a << 1;
                c = a[dataWidth-1];
            end
            opSar: begin
                y = $signed(a) >>> 1;
                c = a[0];
            end
            opAnd:      y = a & b;
            opNotAAndB: y = b & ~a;
            opPassB:    y = b;
            opAAndNotB: y = ~b & a;
            opPassA:    y = a;
            opXor:      y = (a | b) & ~(a & b);
            opOr:       y = a | b;
            opNor:      y = ~(a | b);
            opXnor:     y = (a & b) | ~(a | b);
            opNotA:     y = ~a;
            opNotAOrB:  y = ~(a & ~b);
            opNotB:     y = ~b;
            opAOrNotB:  y = ~(~a & b);
            opNand:     y = ~(a & b);
            opOne:      y = dataWidth'(1);
            default:    y = '0;                             // opZero and unlisted codes
        endcase
        return {y == '0, c, y[dataWidth-1], o, y};
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errCount++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic idleCycle();
        logic [31:0] r;
        r = nextRand();
        @(posedge clk);
        #10;
        instrValid = 1'b0;
        instr      = r[31:12];                              // Junk word must be ignored
    endtask

    // Drive one instruction and queue what it should produce
    task automatic issueInstr(input logic isImm, input logic [opWidth-1:0] op,
            input logic [2:0] rd, input logic [2:0] ra, input logic [2:0] rb,
            input logic [7:0] imm);
        instrWordU            w;
        logic [dataWidth-1:0] opB;
        logic [dataWidth+3:0] expVal;
        w = '0;
        if (isImm) begin
            w.immFmt.isImm = 1'b1;
            w.immFmt.aluOp = op;
            w.immFmt.rd    = rd;
            w.immFmt.ra    = ra;
            w.immFmt.imm   = imm;
            opB = {{(dataWidth-8){imm[7]}}, imm};           // Sign-extended immediate
        end else begin
            w.regFmt.aluOp = op;
            w.regFmt.rd    = rd;
            w.regFmt.ra    = ra;
            w.regFmt.rb    = rb;
            opB = shadow[rb];
        end
        expVal = refAlu(op, shadow[ra], opB);
        @(posedge clk);
        #10;
        expQ.push_back(expVal);
        cycQ.push_back(cycleCount);
        nameQ.push_back(curTest);
        shadow[rd] = expVal[dataWidth-1:0];                 // Later reads see it, as forwarding does
        instr      = w;
        instrValid = 1'b1;
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        errAtStart = errCount;
        testCount++;
    endtask

    task automatic endTest();
        int waitCycles;
        waitCycles = 0;
        while (expQ.size() != 0 && waitCycles < 10) begin
            idleCycle();
            waitCycles++;
        end
        if (expQ.size() != 0) begin                         // Lost results
            $display("%0d results never came out in test %s", expQ.size(), curTest);
            errCount++;
            expQ.delete();
            cycQ.delete();
            nameQ.delete();
        end
        $display("Test %s finished with %0d errors", curTest, errCount - errAtStart);
    endtask

    // Scoreboard sampled mid-cycle when outputs are settled
    always @(negedge clk) begin
        if (arstN && resultValid) begin
            if (expQ.size() == 0) begin
                $display("Result came out with no instruction outstanding in test %s", curTest);
                errCount++;
            end else begin
                gotExp  = expQ.pop_front();
                gotCyc  = cycQ.pop_front();
                gotName = nameQ.pop_front();
                compareValue({gotName, " result"}, 32'(gotExp[dataWidth-1:0]), 32'(result));
                compareValue({gotName, " flags ZCSO"}, 32'(gotExp[dataWidth+3:dataWidth]),
                             32'({flagZ, flagC, flagS, flagO}));
                compareValue({gotName, " latency"}, gotCyc + 2, cycleCount);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Run timed out after %0d cycles without finishing the tests", maxCycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        logic [31:0]        r;
        logic [opWidth-1:0] opList [$];
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        seed       = 32'h6f47491f;
        shadow     = '{default: '0};
        repeat (2) @(posedge clk);
        #10;
        arstN = 1'b1;

        startTest("reset");
        @(negedge clk);
        compareValue("reset resultValid", 0, 32'(resultValid));
        compareValue("reset result", 0, 32'(result));
        compareValue("reset flags", 0, 32'({flagZ, flagC, flagS, flagO}));
        endTest();

        startTest("immArith");
        issueInstr(1'b1, opPassB, 3'd1, 3'd0, 3'd0, 8'h80);   // 0xFF80
        issueInstr(1'b1, opPassB, 3'd2, 3'd0, 3'd0, 8'h7F);
        issueInstr(1'b1, opPassB, 3'd3, 3'd0, 3'd0, 8'hFF);   // 0xFFFF
        issueInstr(1'b1, opPassB, 3'd4, 3'd0, 3'd0, 8'h01);
        issueInstr(1'b1, opPassB, 3'd5, 3'd0, 3'd0, 8'h80);
        repeat (8) issueInstr(1'b0, opShl, 3'd5, 3'd5, 3'd0, 8'h00);  // Walks up to 0x8000
        issueInstr(1'b0, opDec, 3'd6, 3'd5, 3'd0, 8'h00);     // 0x7FFF
        issueInstr(1'b1, opAdd, 3'd7, 3'd6, 3'd0, 8'h01);     // Signed overflow
        issueInstr(1'b0, opAdd, 3'd7, 3'd3, 3'd4, 8'h00);     // Carry and zero
        issueInstr(1'b0, opAddInc, 3'd7, 3'd6, 3'd2, 8'h00);
        issueInstr(1'b0, opSubDec, 3'd7, 3'd1, 3'd2, 8'h00);
        issueInstr(1'b0, opInc, 3'd7, 3'd3, 3'd0, 8'h00);
        issueInstr(1'b1, opSub, 3'd7, 3'd0, 3'd0, 8'h01);     // 0 - 1 borrows
        endTest();

        startTest("hold");
        compareValue("hold result", 32'h0000FFFF, 32'(result));
        compareValue("hold flags", 32'b0110, 32'({flagZ, flagC, flagS, flagO}));
        endTest();

        startTest("forward");
        issueInstr(1'b1, opPassB, 3'd1, 3'd0, 3'd0, 8'h03);
        issueInstr(1'b0, opAdd, 3'd1, 3'd1, 3'd1, 8'h00);     // Both operands bypassed
        issueInstr(1'b1, opAddInc, 3'd2, 3'd1, 3'd0, 8'h05);
        issueInstr(1'b0, opSub, 3'd3, 3'd2, 3'd1, 8'h00);
        issueInstr(1'b0, opXor, 3'd1, 3'd3, 3'd2, 8'h00);
        issueInstr(1'b0, opShl, 3'd1, 3'd1, 3'd0, 8'h00);
        issueInstr(1'b1, opSar, 3'd4, 3'd1, 3'd0, 8'h00);
        issueInstr(1'b0, opAdd, 3'd4, 3'd4, 3'd4, 8'h00);
        issueInstr(1'b1, opSubDec, 3'd4, 3'd4, 3'd0, 8'h10);
        endTest();

        startTest("logic");
        issueInstr(1'b1, opPassB, 3'd1, 3'd0, 3'd0, 8'h5A);
        issueInstr(1'b1, opPassB, 3'd2, 3'd0, 3'd0, 8'hC3);
        opList = '{opZero, opAnd, opNotAAndB, opPassB, opAAndNotB, opPassA, opXor, opOr,
                   opNor, opXnor, opNotA, opNotAOrB, opNotB, opAOrNotB, opNand, opOne,
                   5'b01010};                               // Last one is unlisted
        while (opList.size() != 0) begin
            issueInstr(1'b0, opList.pop_front(), 3'd4, 3'd1, 3'd2, 8'h00);
        end
        endTest();

        startTest("shift");
        issueInstr(1'b1, opPassB, 3'd1, 3'd0, 3'd0, 8'h81);   // Top bit and bit 0 set
        issueInstr(1'b1, opPassB, 3'd2, 3'd0, 3'd0, 8'h41);
        issueInstr(1'b0, opShl, 3'd3, 3'd1, 3'd0, 8'h00);
        issueInstr(1'b0, opSar, 3'd3, 3'd1, 3'd0, 8'h00);
        issueInstr(1'b0, opShl, 3'd4, 3'd2, 3'd0, 8'h00);
        issueInstr(1'b0, opSar, 3'd4, 3'd2, 3'd0, 8'h00);
        endTest();

        startTest("random");
        repeat (300) begin
            r = nextRand();
            issueInstr(r[31], r[30:26], r[25:23], r[22:20], r[19:17], r[16:9]);
            if (r[8:7] == 2'b00) begin                      // Occasional valid gap
                repeat (1 + int'(r[6])) idleCycle();
            end
        end
        endTest();

        $display("Summary %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/aluPkg.sv
hw/alu.sv
hw/regFile.sv
hw/issueStage.sv
hw/execStage.sv
hw/aluCore.sv
bench/aluCoreTb.sv

/* hw/alu.sv */
module alu import aluPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic [opWidth-1:0]   op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] y,
    output logic                 z,                      // Result is zero
    output logic                 c,                      // Carry, borrow or shifted-out bit
    output logic                 s,                      // Sign of result
    output logic                 o                       // Signed overflow
);

    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0] opB;                           // Second arithmetic operand
    logic                 oneIn;                         // Extra +1 or -1 term
    logic [dataWidth:0]   wide;                          // One bit wider sum or difference

    always_comb begin
        opB   = b;
        oneIn = 1'b0;
        wide  = '0;
        y     = '0;                                      // Unlisted codes give zero
        c     = 1'b0;
        o     = 1'b0;
        case (op)
            opAdd, opAddInc, opInc: begin
                if (op == opInc) begin
                    opB = '0;                            // Increment ignores B
                end
                oneIn = (op != opAdd);
                wide  = {1'b0, a} + {1'b0, opB} + {{dataWidth{1'b0}}, oneIn};
                y     = wide[msb:0];
                c     = wide[dataWidth];                 // Carry out of top bit
                // Same-sign operands but result sign flipped
                o     = (a[msb] == opB[msb]) && (y[msb] != a[msb]);
            end
            opSubDec, opSub, opDec: begin
                if (op == opDec) begin
                    opB = '0;                            // Subtrahend is just the 1
                end
                oneIn = (op != opSub);
                wide  = {1'b0, a} - {1'b0, opB} - {{dataWidth{1'b0}}, oneIn};
                y     = wide[msb:0];
                c     = wide[dataWidth];                 // Borrow when subtrahend exceeds a
                // Opposite-sign operands and result sign differs from a
                o     = (a[msb] != opB[msb]) && (y[msb] != a[msb]);
            end
            opShl: begin
                y = {a[msb-1:0], 1'b0};
                c = a[msb];                              // Lost MSB
            end
            opSar: begin
                y = {a[msb], a[msb:1]};                  // Sign bit kept
                c = a[0];                                // Lost LSB
            end
            opZero: begin
                y = '0;
            end
            opAnd: begin
                y = a & b;
            end
            opNotAAndB: begin
                y = ~a & b;
            end
            opPassB: begin
                y = b;
            end
            opAAndNotB: begin
                y = a & ~b;
            end
            opPassA: begin
                y = a;
            end
            opXor: begin
                y = a ^ b;
            end
            opOr: begin
                y = a | b;
            end
            opNor: begin
                y = ~a & ~b;
            end
            opXnor: begin
                y = ~(a ^ b);
            end
            opNotA: begin
                y = ~a;
            end
            opNotAOrB: begin
                y = ~a | b;
            end
            opNotB: begin
                y = ~b;
            end
            opAOrNotB: begin
                y = a | ~b;
            end
            opNand: begin
                y = ~a | ~b;
            end
            opOne: begin
                y = {{(dataWidth-1){1'b0}}, 1'b1};       // Literal one, not all ones
            end
            default: begin
                y = '0;
            end
        endcase
    end

    // Flags common to every opcode
    assign s = y[msb];
    assign z = (y == '0);

endmodule

/* hw/aluCore.sv */
module aluCore import aluPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  instrWordU            instr,
    output logic [dataWidth-1:0] result,
    output logic                 resultValid,
    output logic                 flagZ,
    output logic                 flagC,
    output logic                 flagS,
    output logic                 flagO
);

    logic [regAddrWidth-1:0] rdAddrA, rdAddrB;           // Issue read addresses
    logic [dataWidth-1:0]    rdDataA, rdDataB;
    logic                    wbEn;                       // Write-back and bypass source
    logic [regAddrWidth-1:0] wbAddr;
    logic [dataWidth-1:0]    wbData;
    logic                    exValid;                    // Issue to execute
    logic [opWidth-1:0]      exOp;
    logic [dataWidth-1:0]    exA, exB;
    logic [regAddrWidth-1:0] exRd;

    regFile #(.dataWidth(dataWidth)) regFileInst (
        .clk    (clk),
        .arstN  (arstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    issueStage #(.dataWidth(dataWidth)) issueInst (
        .clk       (clk),
        .arstN     (arstN),
        .instrValid(instrValid),
        .instr     (instr),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .wbEn      (wbEn),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .exValid   (exValid),
        .exOp      (exOp),
        .exA       (exA),
        .exB       (exB),
        .exRd      (exRd)
    );

    execStage #(.dataWidth(dataWidth)) execInst (
        .clk        (clk),
        .arstN      (arstN),
        .exValid    (exValid),
        .exOp       (exOp),
        .exA        (exA),
        .exB        (exB),
        .exRd       (exRd),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .result     (result),
        .resultValid(resultValid),
        .flagZ      (flagZ),
        .flagC      (flagC),
        .flagS      (flagS),
        .flagO      (flagO)
    );

endmodule

/* hw/aluPkg.sv */
package aluPkg;

    localparam int opWidth      = 5;                     // ALU opcode width
    localparam int regAddrWidth = 3;                     // Eight registers
    localparam int immWidth     = 8;                     // Immediate field width

    // Arithmetic group
    localparam logic [opWidth-1:0] opAdd      = 5'b00000; // A + B
    localparam logic [opWidth-1:0] opAddInc   = 5'b00001; // A + B + 1
    localparam logic [opWidth-1:0] opInc      = 5'b00011; // A + 1
    localparam logic [opWidth-1:0] opSubDec   = 5'b00100; // A - B - 1
    localparam logic [opWidth-1:0] opSub      = 5'b00101; // A - B
    localparam logic [opWidth-1:0] opDec      = 5'b00110; // A - 1

    // Shift group
    localparam logic [opWidth-1:0] opShl      = 5'b01000; // A << 1
    localparam logic [opWidth-1:0] opSar      = 5'b01001; // A >>> 1

    // Logic and constant group
    localparam logic [opWidth-1:0] opZero     = 5'b10000; // 0
    localparam logic [opWidth-1:0] opAnd      = 5'b10001; // A & B
    localparam logic [opWidth-1:0] opNotAAndB = 5'b10010; // ~A & B
    localparam logic [opWidth-1:0] opPassB    = 5'b10011; // B
    localparam logic [opWidth-1:0] opAAndNotB = 5'b10100; // A & ~B
    localparam logic [opWidth-1:0] opPassA    = 5'b10101; // A
    localparam logic [opWidth-1:0] opXor      = 5'b10110; // A ^ B
    localparam logic [opWidth-1:0] opOr       = 5'b10111; // A | B
    localparam logic [opWidth-1:0] opNor      = 5'b11000; // ~A & ~B
    localparam logic [opWidth-1:0] opXnor     = 5'b11001; // ~(A ^ B)
    localparam logic [opWidth-1:0] opNotA     = 5'b11010; // ~A
    localparam logic [opWidth-1:0] opNotAOrB  = 5'b11011; // ~A | B
    localparam logic [opWidth-1:0] opNotB     = 5'b11100; // ~B
    localparam logic [opWidth-1:0] opAOrNotB  = 5'b11101; // A | ~B
    localparam logic [opWidth-1:0] opNand     = 5'b11110; // ~A | ~B
    localparam logic [opWidth-1:0] opOne      = 5'b11111; // Constant 1

    // Register-register format, MSB first
    typedef struct packed {
        logic                    isImm;                  // Low in this view
        logic [opWidth-1:0]      aluOp;
        logic [regAddrWidth-1:0] rd;                     // Destination
        logic [regAddrWidth-1:0] ra;                     // Operand A source
        logic [regAddrWidth-1:0] rb;                     // Operand B source
        logic [4:0]              spare;                  // Pads to word size
    } instrRegS;

    // Register-immediate format, same leading fields
    typedef struct packed {
        logic                    isImm;                  // High in this view
        logic [opWidth-1:0]      aluOp;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] ra;
        logic [immWidth-1:0]     imm;                    // Signed, extended in issue
    } instrImmS;

    // 20-bit instruction word, decoded by isImm
    typedef union packed {
        instrRegS regFmt;
        instrImmS immFmt;
    } instrWordU;

endpackage

/* hw/execStage.sv */
module execStage import aluPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    exValid,
    input  logic [opWidth-1:0]      exOp,
    input  logic [dataWidth-1:0]    exA,
    input  logic [dataWidth-1:0]    exB,
    input  logic [regAddrWidth-1:0] exRd,
    output logic                    wbEn,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData,
    output logic [dataWidth-1:0]    result,
    output logic                    resultValid,
    output logic                    flagZ,
    output logic                    flagC,
    output logic                    flagS,
    output logic                    flagO
);

    logic [dataWidth-1:0] aluY;
    logic                 aluZ, aluC, aluS, aluO;

    alu #(
        .dataWidth(dataWidth)
    ) aluInst (
        .op(exOp),
        .a (exA),
        .b (exB),
        .y (aluY),
        .z (aluZ),
        .c (aluC),
        .s (aluS),
        .o (aluO)
    );

    // Every valid instruction writes rd, taken at the next edge
    assign wbEn   = exValid;
    assign wbAddr = exRd;
    assign wbData = aluY;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result      <= '0;
            resultValid <= 1'b0;
            {flagZ, flagC, flagS, flagO} <= 4'b0000;
        end else begin
            resultValid <= exValid;                      // One-cycle pulse per instruction
            if (exValid) begin                           // Hold last result between instructions
                result <= aluY;
                {flagZ, flagC, flagS, flagO} <= {aluZ, aluC, aluS, aluO};
            end
        end
    end

endmodule

/* hw/issueStage.sv */
module issueStage import aluPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    instrValid,
    input  instrWordU               instr,
    output logic [regAddrWidth-1:0] rdAddrA,
    output logic [regAddrWidth-1:0] rdAddrB,
    input  logic [dataWidth-1:0]    rdDataA,
    input  logic [dataWidth-1:0]    rdDataB,
    input  logic                    wbEn,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [dataWidth-1:0]    wbData,
    output logic                    exValid,
    output logic [opWidth-1:0]      exOp,
    output logic [dataWidth-1:0]    exA,
    output logic [dataWidth-1:0]    exB,
    output logic [regAddrWidth-1:0] exRd
);

    logic [dataWidth-1:0] fwdA;                          // Operand A after bypass
    logic [dataWidth-1:0] fwdB;                          // Register B after bypass
    logic [dataWidth-1:0] immExt;                        // Sign-extended immediate
    logic [dataWidth-1:0] opB;                           // Selected operand B

    // Leading fields sit at the same bits in both views
    assign rdAddrA = instr.regFmt.ra;
    assign rdAddrB = instr.regFmt.rb;                    // Don't care in immediate format

    // Bypass the result still sitting in execute
    assign fwdA = (wbEn && (wbAddr == rdAddrA)) ? wbData : rdDataA;
    assign fwdB = (wbEn && (wbAddr == rdAddrB)) ? wbData : rdDataB;

    assign immExt = {{(dataWidth-immWidth){instr.immFmt.imm[immWidth-1]}},
                     instr.immFmt.imm};

    assign opB = instr.immFmt.isImm ? immExt : fwdB;

    // Valid bit is the only control state here
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= instrValid;
        end
    end

    // Operands and fields load every cycle, qualified downstream by exValid
    always_ff @(posedge clk) begin
        exOp <= instr.regFmt.aluOp;
        exA  <= fwdA;
        exB  <= opB;
        exRd <= instr.regFmt.rd;
    end

endmodule

/* hw/regFile.sv */
module regFile import aluPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rdAddrA,
    input  logic [regAddrWidth-1:0] rdAddrB,
    output logic [dataWidth-1:0]    rdDataA,
    output logic [dataWidth-1:0]    rdDataB,
    input  logic                    wbEn,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [dataWidth-1:0]    wbData
);

    localparam int numRegs = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [numRegs];                // Architectural registers

    // Single write port, whole file cleared on reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wbEn) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Raw reads, forwarding is done in issue
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module aluCoreTb -f filelist.f --Mdir obj_dir -o aluCoreSim
./obj_dir/aluCoreSim > sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished cleanly"
